//--- Bender.yml
package:
  name: dcache

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dcache_types_pkg.sv
      - verilog/dcache_ctrl_pkg.sv
      - verilog/dtag_bank.sv
      - verilog/ddata_bank.sv
      - verilog/dcache_lookup.sv
      - verilog/dcache_miss_unit.sv
      - verilog/dcache.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/dcache_checker.sv
      - verif/dcache_tb.sv

//--- list.f
+incdir+verilog
verilog/dcache_types_pkg.sv
verilog/dcache_ctrl_pkg.sv
verilog/dtag_bank.sv
verilog/ddata_bank.sv
verilog/dcache_lookup.sv
verilog/dcache_miss_unit.sv
verilog/dcache.sv
verif/dcache_checker.sv
verif/dcache_tb.sv

//--- verif/dcache_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module dcache_checker
    import dcache_types_pkg::*;
(
    input wire            clk,
    input wire            rst,
    input wire            new_request,
    input wire            ready,
    input wire            data_valid,
    input wire            mem_request,
    input wire            mem_ack,
    input wire addr_t     mem_addr,
    input wire            mem_rnw,
    input wire be_t       mem_be,
    input wire word_t     mem_wdata,
    input wire word_idx_t mem_size
);

    int   violations = 0;
    logic rst_q;

    // Reset one cycle late, skips the power-up cycle
    always_ff @(posedge clk)
        rst_q <= rst;

    //////////////////////////////////////////////////
    // Memory request held with stable fields until ack
    request_held: assert property (@(posedge clk) disable iff (rst)
        mem_request && !mem_ack |=> mem_request && $stable(mem_addr) && $stable(mem_rnw)
            && $stable(mem_be) && $stable(mem_wdata) && $stable(mem_size))
    else begin
        violations++;
        $error("mem_request dropped or its fields changed before mem_ack");
    end

    // Processor issues only into a ready cache
    request_when_ready: assert property (@(posedge clk) disable iff (rst)
        new_request |-> ready)
    else begin
        violations++;
        $error("new_request issued while ready was low");
    end

    // No load data while in reset
    quiet_in_reset: assert property (@(posedge clk)
        rst && rst_q |-> !data_valid)
    else begin
        violations++;
        $error("data_valid high during reset");
    end

endmodule

`default_nettype wire

//--- verif/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module dcache_tb
    import dcache_types_pkg::*;
();

    localparam int MEM_WORDS = 1024;
    localparam int TIMEOUT   = 200;

    logic      clk;
    logic      rst;
    logic      new_request;
    addr_t     addr;
    logic      load;
    logic      store;
    be_t       be;
    word_t     data_in;
    logic      dcache_on;
    word_t     data_out;
    logic      data_valid;
    logic      ready;
    logic      mem_request;
    addr_t     mem_addr;
    logic      mem_rnw;
    be_t       mem_be;
    word_t     mem_wdata;
    word_idx_t mem_size;
    logic      mem_ack;
    word_t     mem_rdata;
    logic      mem_rdata_valid;

    // Memory model contents and expected processor view
    word_t     mem_words [MEM_WORDS];
    word_t     shadow [MEM_WORDS];
    // Owed load results in issue order
    word_t     expected_q [$];
    integer    seed = 32'h65f31557;
    int        txn_count;
    word_idx_t last_size;
    logic      last_rnw;

    dcache uut (.*);

    bind dcache dcache_checker protocol_check (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers
    task automatic report_error(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
        else report_error($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    endtask

    // Every bit of the word index shows up in the word
    function automatic word_t init_pattern(input int unsigned idx);
        logic [9:0] w;
        w = idx[9:0];
        return {6'h2b, w, ~w, 6'h19};
    endfunction

    function automatic int unsigned word_index(input addr_t a);
        return a[11:2];
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t wdata, input be_t mask);
        word_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (mask[i])
                res[i*8 +: 8] = wdata[i*8 +: 8];
        end
        return res;
    endfunction

    //////////////////////////////////////////////////
    // Memory model with random ack delay and burst gaps
    task automatic serve_memory();
        int unsigned delay;
        int unsigned gap;
        int unsigned beats;
        int unsigned base;
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(negedge clk);
        mem_ack = 1'b1;
        txn_count++;
        last_size = mem_size;
        last_rnw = mem_rnw;
        beats = mem_size + 1;
        // Bursts start at word 0 of the line
        if (beats > 1)
            base = word_index(mem_addr) & ~(`DCACHE_LINE_W - 1);
        else
            base = word_index(mem_addr);
        if (!mem_rnw)
            mem_words[base] = merge_bytes(mem_words[base], mem_wdata, mem_be);
        @(negedge clk);
        mem_ack = 1'b0;
        if (mem_rnw) begin
            for (int i = 0; i < beats; i++) begin
                gap = $unsigned($random(seed)) % 3;
                repeat (gap) @(negedge clk);
                mem_rdata = mem_words[base + i];
                mem_rdata_valid = 1'b1;
                @(negedge clk);
                mem_rdata_valid = 1'b0;
            end
        end
    endtask

    initial begin
        mem_ack = 1'b0;
        mem_rdata_valid = 1'b0;
        mem_rdata = '0;
        txn_count = 0;
        last_size = '0;
        last_rnw = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++)
            mem_words[i] = init_pattern(i);
        forever begin
            @(negedge clk);
            if (!rst && mem_request === 1'b1)
                serve_memory();
        end
    end

    //////////////////////////////////////////////////
    // Processor side
    task automatic drive_request(input addr_t a, input logic is_load, input be_t mask,
                                 input word_t wdata);
        new_request = 1'b1;
        addr = a;
        load = is_load;
        store = !is_load;
        be = mask;
        data_in = wdata;
        if (is_load)
            expected_q.push_back(shadow[word_index(a)]);
        else
            shadow[word_index(a)] = merge_bytes(shadow[word_index(a)], wdata, mask);
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT)
                report_error("Cache never became ready after a request");
        end while (ready !== 1'b1);
    endtask

    task automatic run_access(input addr_t a, input logic is_load, input be_t mask,
                              input word_t wdata);
        @(negedge clk);
        drive_request(a, is_load, mask, wdata);
        @(negedge clk);
        new_request = 1'b0;
        wait_ready();
    endtask

    // Loads issued every cycle in the previous hit's cycle 1
    task automatic load_chain(input addr_t first, input int n);
        for (int k = 0; k < n + 2; k++) begin
            @(negedge clk);
            // Hit data due two cycles after its request
            if (k >= 2)
                expect_equal("data_valid", data_valid, 1);
            if (k < n)
                drive_request(first + addr_t'(4 * k), 1'b1, 4'hf, '0);
            else
                new_request = 1'b0;
        end
        wait_ready();
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT)
                report_error("A load never returned its data");
        end
    endtask

    // Load data against the oldest owed word
    always @(posedge clk) begin
        if (!rst && data_valid === 1'b1) begin
            assert (expected_q.size() != 0)
            else report_error("data_valid pulsed with no load outstanding");
            assert (data_out === expected_q[0])
            else report_error($sformatf("FAILED data_out: got %h expected %h",
                                        data_out, expected_q[0]));
            void'(expected_q.pop_front());
        end
    end

    always @(uut.protocol_check.violations) begin
        if (uut.protocol_check.violations != 0)
            report_error("A protocol assertion in the checker fired");
    end

    //////////////////////////////////////////////////
    // Stimulus
    initial begin
        int    base_txn;
        addr_t a;
        logic  is_load;
        rst = 1'b1;
        new_request = 1'b0;
        addr = '0;
        load = 1'b0;
        store = 1'b0;
        be = '0;
        data_in = '0;
        dcache_on = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++)
            shadow[i] = init_pattern(i);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Idle after reset
        @(posedge clk);
        expect_equal("ready", ready, 1);
        expect_equal("mem_request", mem_request, 0);
        expect_equal("data_valid", data_valid, 0);

        // Cold line takes a full burst
        run_access(32'h124, 1'b1, 4'hf, '0);
        expect_equal("txn_count", txn_count, 1);
        expect_equal("mem_size", last_size, `DCACHE_LINE_W - 1);
        expect_equal("mem_rnw", last_rnw, 1);

        // Hits in the same line and then back to back
        base_txn = txn_count;
        run_access(32'h128, 1'b1, 4'hf, '0);
        run_access(32'h120, 1'b1, 4'hf, '0);
        load_chain(32'h120, 4);
        expect_equal("txn_count", txn_count, base_txn);

        // Byte store writes through and a hit sees the merged word
        run_access(32'h128, 1'b0, 4'b0110, 32'hdeadbeef);
        expect_equal("txn_count", txn_count, base_txn + 1);
        expect_equal("mem_rnw", last_rnw, 0);
        expect_equal("mem_words", mem_words[word_index(32'h128)], shadow[word_index(32'h128)]);
        run_access(32'h128, 1'b1, 4'hf, '0);
        expect_equal("txn_count", txn_count, base_txn + 1);

        // Cache off gives single-word reads every time
        @(negedge clk);
        dcache_on = 1'b0;
        for (int k = 0; k < 2; k++) begin
            base_txn = txn_count;
            run_access(32'h124, 1'b1, 4'hf, '0);
            expect_equal("txn_count", txn_count, base_txn + 1);
            expect_equal("mem_size", last_size, 0);
        end
        @(negedge clk);
        dcache_on = 1'b1;

        // Four tags into set 5 with two ways
        base_txn = txn_count;
        for (int p = 0; p < 2; p++) begin
            for (int k = 0; k < 4; k++) begin
                a = addr_t'(32'h050 + k * 32'h100 + ($unsigned($random(seed)) % 4) * 4);
                run_access(a, 1'b1, 4'hf, '0);
            end
        end
        assert (txn_count >= base_txn + 6)
        else report_error("Conflicting lines in one set did not cause refills");

        // Mixed traffic over 64 lines
        for (int k = 0; k < 40; k++) begin
            a = addr_t'(($unsigned($random(seed)) % 256) * 4);
            is_load = ($unsigned($random(seed)) % 3) != 0;
            run_access(a, is_load, is_load ? 4'hf : be_t'($random(seed)),
                       word_t'($random(seed)));
        end

        wait_drain();
        @(negedge clk);
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/dcache.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module dcache
    import dcache_types_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    // Load/store unit
    input  wire            new_request,
    input  wire addr_t     addr,
    input  wire            load,
    input  wire            store,
    input  wire be_t       be,
    input  wire word_t     data_in,
    input  wire            dcache_on,
    output word_t          data_out,
    output logic           data_valid,
    output logic           ready,
    // Memory
    output logic           mem_request,
    output addr_t          mem_addr,
    output logic           mem_rnw,
    output be_t            mem_be,
    output word_t          mem_wdata,
    output word_idx_t      mem_size,
    input  wire            mem_ack,
    input  wire word_t     mem_rdata,
    input  wire            mem_rdata_valid
);

    logic       s2_valid;
    addr_t      s2_addr;
    logic       s2_load;
    logic       s2_store;
    be_t        s2_be;
    word_t      s2_data;
    logic       read_hit_allowed;
    logic       read_hit_data_valid;
    way_vec_t   fill_way;
    way_idx_t   hit_way_idx;
    way_idx_t   fill_way_idx;
    logic       tag_hit;
    way_vec_t   hit_way;
    logic       tag_update;
    logic       fill_en;
    bank_addr_t fill_addr;
    word_t      fill_data;
    word_t      miss_data;
    word_t      bank_data;
    bank_addr_t bank_addr_a;
    be_t        write_hit_be;

    //////////////////////////////////////////////////
    // Stage 1 to 2
    dcache_lookup lookup (
        .clk                 (clk),
        .rst                 (rst),
        .new_request         (new_request),
        .addr                (addr),
        .load                (load),
        .store               (store),
        .be                  (be),
        .data_in             (data_in),
        .dcache_on           (dcache_on),
        .tag_hit             (tag_hit),
        .hit_way             (hit_way),
        .s2_valid            (s2_valid),
        .s2_addr             (s2_addr),
        .s2_load             (s2_load),
        .s2_store            (s2_store),
        .s2_be               (s2_be),
        .s2_data             (s2_data),
        .read_hit_allowed    (read_hit_allowed),
        .read_hit_data_valid (read_hit_data_valid),
        .fill_way            (fill_way),
        .hit_way_idx         (hit_way_idx),
        .fill_way_idx        (fill_way_idx)
    );

    dtag_bank tags (
        .clk        (clk),
        .rst        (rst),
        .s1_adv     (new_request),
        .s1_addr    (addr),
        .s2_addr    (s2_addr),
        .update     (tag_update),
        .update_way (fill_way),
        .tag_hit    (tag_hit),
        .hit_way    (hit_way)
    );

    //////////////////////////////////////////////////
    // Data storage
    // Stores write only on a hit and loads never write
    assign write_hit_be = s2_be & {4{tag_hit & s2_store}};
    assign bank_addr_a  = {hit_way_idx,
        s2_addr[`DCACHE_WORD_LSB +: `DCACHE_SET_W + `DCACHE_WORD_W]};

    ddata_bank data_bank (
        .clk        (clk),
        .addr_a     (bank_addr_a),
        .addr_b     (fill_addr),
        .en_a       (s2_valid),
        .en_b       (fill_en),
        .be_a       (write_hit_be),
        .data_in_a  (s2_data),
        .data_in_b  (fill_data),
        .data_out_a (bank_data)
    );

    //////////////////////////////////////////////////
    // Memory side and completion
    dcache_miss_unit miss_unit (
        .clk              (clk),
        .rst              (rst),
        .new_request      (new_request),
        .s2_valid         (s2_valid),
        .s2_addr          (s2_addr),
        .s2_load          (s2_load),
        .s2_store         (s2_store),
        .s2_be            (s2_be),
        .s2_data          (s2_data),
        .dcache_on        (dcache_on),
        .read_hit_allowed (read_hit_allowed),
        .tag_hit          (tag_hit),
        .fill_way_idx     (fill_way_idx),
        .mem_ack          (mem_ack),
        .mem_rdata        (mem_rdata),
        .mem_rdata_valid  (mem_rdata_valid),
        .mem_request      (mem_request),
        .mem_addr         (mem_addr),
        .mem_rnw          (mem_rnw),
        .mem_be           (mem_be),
        .mem_wdata        (mem_wdata),
        .mem_size         (mem_size),
        .tag_update       (tag_update),
        .fill_en          (fill_en),
        .fill_addr        (fill_addr),
        .fill_data        (fill_data),
        .miss_data        (miss_data),
        .data_valid       (data_valid),
        .ready            (ready)
    );

    // Hit data straight from the bank and miss data from the capture register
    assign data_out = read_hit_data_valid ? bank_data : miss_data;

endmodule

`default_nettype wire

//--- verilog/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Cache geometry
`define DCACHE_WAYS       2
`define DCACHE_SETS       16
`define DCACHE_LINE_W     4
`define DCACHE_ADDR_W     32

// Derived field widths
`define DCACHE_WAY_W      $clog2(`DCACHE_WAYS)
`define DCACHE_SET_W      $clog2(`DCACHE_SETS)
`define DCACHE_WORD_W     $clog2(`DCACHE_LINE_W)
`define DCACHE_TAG_W      (`DCACHE_ADDR_W - `DCACHE_SET_W - `DCACHE_WORD_W)

// Address layout, byte offset sits below the word index
`define DCACHE_WORD_LSB   2
`define DCACHE_SET_LSB    (`DCACHE_WORD_LSB + `DCACHE_WORD_W)
`define DCACHE_BANK_WORDS (`DCACHE_WAYS * `DCACHE_SETS * `DCACHE_LINE_W)

`endif

//--- verilog/dcache_ctrl_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package dcache_ctrl_pkg;

    // Miss unit FSM
    typedef enum logic [1:0] {
        MISS_IDLE,    // no memory traffic
        MISS_REQUEST, // holding request until ack
        MISS_FILL,    // collecting burst words
        MISS_DONE     // single completion cycle
    } miss_state_t;

endpackage

`default_nettype wire

//--- verilog/dcache_lookup.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module dcache_lookup
    import dcache_types_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire           new_request,
    input  wire addr_t    addr,
    input  wire           load,
    input  wire           store,
    input  wire be_t      be,
    input  wire word_t    data_in,
    input  wire           dcache_on,
    input  wire           tag_hit,
    input  wire way_vec_t hit_way,
    output logic          s2_valid,
    output addr_t         s2_addr,
    output logic          s2_load,
    output logic          s2_store,
    output be_t           s2_be,
    output word_t         s2_data,
    output logic          read_hit_allowed,
    output logic          read_hit_data_valid,
    output way_vec_t      fill_way,
    output way_idx_t      hit_way_idx,
    output way_idx_t      fill_way_idx
);

    way_vec_t repl_way;

    // One-hot way to binary
    function automatic way_idx_t onehot_to_idx(input way_vec_t oh);
        way_idx_t idx;
        idx = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (oh[w])
                idx = idx | way_idx_t'(w);
        end
        return idx;
    endfunction

    //////////////////////////////////////////////////
    // Stage 2 request register
    always_ff @(posedge clk) begin
        if (new_request) begin
            s2_addr  <= addr;
            s2_load  <= load;
            s2_store <= store;
            s2_be    <= be;
            s2_data  <= data_in;
        end
    end

    // Single-cycle stage 2 strobes
    // Cacheable loads may hit, everything else goes to memory
    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid            <= 1'b0;
            read_hit_allowed    <= 1'b0;
            read_hit_data_valid <= 1'b0;
        end else begin
            s2_valid            <= new_request;
            read_hit_allowed    <= new_request & load & dcache_on;
            // Bank output is selected the cycle after a hit
            read_hit_data_valid <= read_hit_allowed & tag_hit;
        end
    end

    //////////////////////////////////////////////////
    // Replacement, free-running one-hot cycler
    always_ff @(posedge clk) begin
        if (rst)
            repl_way <= way_vec_t'(1);
        else
            repl_way <= {repl_way[`DCACHE_WAYS-2:0], repl_way[`DCACHE_WAYS-1]};
    end

    // Way picked while request sits in stage 2
    always_ff @(posedge clk) begin
        if (s2_valid)
            fill_way <= repl_way;
    end

    assign hit_way_idx  = onehot_to_idx(hit_way);
    assign fill_way_idx = onehot_to_idx(fill_way);

endmodule

`default_nettype wire

//--- verilog/dcache_miss_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module dcache_miss_unit
    import dcache_types_pkg::*;
    import dcache_ctrl_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire           new_request,
    input  wire           s2_valid,
    input  wire addr_t    s2_addr,
    input  wire           s2_load,
    input  wire           s2_store,
    input  wire be_t      s2_be,
    input  wire word_t    s2_data,
    input  wire           dcache_on,
    input  wire           read_hit_allowed,
    input  wire           tag_hit,
    input  wire way_idx_t fill_way_idx,
    input  wire           mem_ack,
    input  wire word_t    mem_rdata,
    input  wire           mem_rdata_valid,
    output logic          mem_request,
    output addr_t         mem_addr,
    output logic          mem_rnw,
    output be_t           mem_be,
    output word_t         mem_wdata,
    output word_idx_t     mem_size,
    output logic          tag_update,
    output logic          fill_en,
    output bank_addr_t    fill_addr,
    output word_t         fill_data,
    output word_t         miss_data,
    output logic          data_valid,
    output logic          ready
);

    miss_state_t state;
    miss_state_t next_state;
    miss_state_t ack_state;
    word_idx_t   word_count;
    logic        read_hit;
    logic        need_mem;
    logic        line_fill_q;
    logic        line_fill;
    logic        burst_word;
    logic        is_target_word;
    logic        store_complete;
    logic        idle;

    assign read_hit = read_hit_allowed & tag_hit;
    // Any store, a load miss, or any load with the cache off
    assign need_mem = s2_valid & ~read_hit;

    // Cacheable loads fetch a full line
    always_ff @(posedge clk) begin
        if (rst)
            line_fill_q <= 1'b0;
        else if (s2_valid)
            line_fill_q <= s2_load & dcache_on;
    end
    assign line_fill = s2_valid ? (s2_load & dcache_on) : line_fill_q;

    //////////////////////////////////////////////////
    // Memory port, fields stable until ack
    assign mem_request = need_mem | (state == MISS_REQUEST);
    assign mem_addr    = {s2_addr[`DCACHE_ADDR_W-1:2], 2'b00};
    assign mem_rnw     = s2_load;
    assign mem_be      = s2_be;
    assign mem_wdata   = s2_data;
    assign mem_size    = line_fill ? word_idx_t'(`DCACHE_LINE_W - 1) : '0;

    //////////////////////////////////////////////////
    // Miss FSM
    assign ack_state = s2_load ? MISS_FILL : MISS_IDLE;

    always_comb begin
        next_state = state;
        case (state)
            MISS_IDLE:    if (need_mem) next_state = mem_ack ? ack_state : MISS_REQUEST;
            MISS_REQUEST: if (mem_ack) next_state = ack_state;
            MISS_FILL:    if (burst_word & (word_count == mem_size)) next_state = MISS_DONE;
            MISS_DONE:    next_state = MISS_IDLE;
            default:      next_state = MISS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= MISS_IDLE;
        else
            state <= next_state;
    end

    // Burst word counter, restarts for every miss
    assign burst_word = (state == MISS_FILL) & mem_rdata_valid;

    always_ff @(posedge clk) begin
        if (rst)
            word_count <= '0;
        else if (state != MISS_FILL)
            word_count <= '0;
        else if (mem_rdata_valid)
            word_count <= word_count + 1'b1;
    end

    // Single-word reads return the target directly
    assign is_target_word = ~line_fill |
        (word_count == s2_addr[`DCACHE_WORD_LSB +: `DCACHE_WORD_W]);

    //////////////////////////////////////////////////
    // Line fill through bank port b
    assign fill_en   = burst_word & line_fill;
    assign fill_addr = {fill_way_idx, s2_addr[`DCACHE_SET_LSB +: `DCACHE_SET_W], word_count};
    assign fill_data = mem_rdata;

    always_ff @(posedge clk) begin
        if (burst_word & is_target_word)
            miss_data <= mem_rdata;
    end

    //////////////////////////////////////////////////
    // Completion
    // Tag marked valid up front, next request waits for ready anyway
    always_ff @(posedge clk) begin
        if (rst) begin
            tag_update <= 1'b0;
            data_valid <= 1'b0;
        end else begin
            tag_update <= s2_valid & s2_load & dcache_on & ~tag_hit;
            data_valid <= (burst_word & is_target_word) | read_hit;
        end
    end

    assign store_complete = mem_request & mem_ack & s2_store;

    always_ff @(posedge clk) begin
        if (rst)
            idle <= 1'b1;
        else if (new_request)
            idle <= 1'b0;
        else if (read_hit | store_complete | (state == MISS_DONE))
            idle <= 1'b1;
    end

    assign ready = read_hit | store_complete | (state == MISS_DONE) | idle;

endmodule

`default_nettype wire

//--- verilog/dcache_types_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package dcache_types_pkg;

    // Processor side
    typedef logic [`DCACHE_ADDR_W-1:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] be_t;

    // Address fields
    typedef logic [`DCACHE_SET_W-1:0] set_idx_t;
    typedef logic [`DCACHE_WORD_W-1:0] word_idx_t;
    // Top address bits, overlaps the upper set bits
    typedef logic [`DCACHE_TAG_W-1:0] tag_t;

    // Way selection
    typedef logic [`DCACHE_WAYS-1:0] way_vec_t;
    typedef logic [`DCACHE_WAY_W-1:0] way_idx_t;

    // Data bank word address: way, set, word
    typedef logic [`DCACHE_WAY_W+`DCACHE_SET_W+`DCACHE_WORD_W-1:0] bank_addr_t;

endpackage

`default_nettype wire

//--- verilog/ddata_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module ddata_bank
    import dcache_types_pkg::*;
(
    input  wire             clk,
    input  wire bank_addr_t addr_a,
    input  wire bank_addr_t addr_b,
    input  wire             en_a,
    input  wire             en_b,
    input  wire be_t        be_a,
    input  wire word_t      data_in_a,
    input  wire word_t      data_in_b,
    output word_t           data_out_a
);

    word_t ram [`DCACHE_BANK_WORDS];

    // Port a: hit read and byte-enabled store write
    // Port b: whole-word line fill
    always_ff @(posedge clk) begin
        if (en_a) begin
            data_out_a <= ram[addr_a];
            for (int i = 0; i < $bits(be_t); i++) begin
                if (be_a[i])
                    ram[addr_a][i*8 +: 8] <= data_in_a[i*8 +: 8];
            end
        end
        if (en_b)
            ram[addr_b] <= data_in_b;
    end

endmodule

`default_nettype wire

//--- verilog/dtag_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module dtag_bank
    import dcache_types_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire           s1_adv,
    input  wire addr_t    s1_addr,
    input  wire addr_t    s2_addr,
    input  wire           update,
    input  wire way_vec_t update_way,
    output logic          tag_hit,
    output way_vec_t      hit_way
);

    tag_t     tags  [`DCACHE_WAYS][`DCACHE_SETS];
    logic     valid [`DCACHE_WAYS][`DCACHE_SETS];
    tag_t     rd_tag [`DCACHE_WAYS];
    way_vec_t rd_valid;
    set_idx_t s1_set;
    set_idx_t s2_set;
    tag_t     s2_tag;

    assign s1_set = s1_addr[`DCACHE_SET_LSB +: `DCACHE_SET_W];
    assign s2_set = s2_addr[`DCACHE_SET_LSB +: `DCACHE_SET_W];
    assign s2_tag = s2_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];

    //////////////////////////////////////////////////
    // Stage 1 lookup, registered read of every way
    always_ff @(posedge clk) begin
        if (s1_adv) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                rd_tag[w]   <= tags[w][s1_set];
                rd_valid[w] <= valid[w][s1_set];
            end
        end
    end

    // Line update writes stage 2 tag into fill way
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (update & update_way[w])
                tags[w][s2_set] <= s2_tag;
        end
    end

    // Valid bits, whole array swept clear on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                for (int s = 0; s < `DCACHE_SETS; s++)
                    valid[w][s] <= 1'b0;
            end
        end else begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                if (update & update_way[w])
                    valid[w][s2_set] <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Stage 2 compare
    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++)
            hit_way[w] = rd_valid[w] & (rd_tag[w] == s2_tag);
    end

    assign tag_hit = |hit_way;

endmodule

`default_nettype wire
